//--- bench/mem_model.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module mem_model (
    input  logic                   upstream_intf,
    input  logic                   rst_n,
    input  logic [`ADDR_W-1:0]     haddr_m,
    input  ahb_cache_pkg::htrans_t htrans_m,
    output logic                   hready_m,
    output logic [`DATA_W-1:0]     hrdata_m
);

    import ahb_cache_pkg::*;

    // address phase seen during the previous cycle
    logic               aph_active;
    logic [`ADDR_W-1:0] aph_addr;

    // data phase in progress
    logic               dph_active;
    logic [`ADDR_W-1:0] dph_addr;
    int unsigned        wait_left;

    // outputs change on the falling edge, the cache samples on the rising edge
    always @(negedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            aph_active = 1'b0;
            aph_addr   = '0;
            dph_active = 1'b0;
            dph_addr   = '0;
            wait_left  = 0;
            hready_m  <= 1'b1;
            hrdata_m  <= '0;
        end else begin
            // rising edge just gone: did a data phase end, did an address phase start
            if (hready_m) begin
                dph_active = aph_active;
                dph_addr   = aph_addr;
                if (aph_active) begin
                    wait_left = $urandom % 3;
                end else begin
                    wait_left = 0;
                end
            end else begin
                wait_left = wait_left - 1;
            end

            hready_m <= !dph_active || (wait_left == 0);
            // data is the inverse of the beat address
            hrdata_m <= ~dph_addr;

            aph_active = (htrans_m == NONSEQ) || (htrans_m == SEQ);
            aph_addr   = haddr_m;
        end
    end

endmodule

//--- bench/tb_ahb_read_cache.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module tb_ahb_read_cache;

    import ahb_cache_pkg::*;

    localparam int NUM_LINES  = 64;
    localparam int IDX_W      = $clog2(NUM_LINES);
    localparam int MAX_CYCLES = 4000;

    logic               upstream_intf;
    logic               rst_n;
    logic [`ADDR_W-1:0] haddr;
    htrans_t            htrans;
    logic               hwrite;
    logic [2:0]         hsize;
    logic               hready;
    logic [`DATA_W-1:0] hrdata;
    logic [`ADDR_W-1:0] haddr_m;
    htrans_t            htrans_m;
    hburst_t            hburst_m;
    logic               hready_m;
    logic [`DATA_W-1:0] hrdata_m;
    logic               cfg_wr;
    logic [1:0]         cfg_addr;
    logic [`DATA_W-1:0] cfg_wdata;
    logic [`DATA_W-1:0] cfg_rdata;

    // reference model of the tag store
    logic               ref_valid [NUM_LINES];
    logic [31:0]        ref_tag [NUM_LINES];
    logic               ref_enable;
    logic [31:0]        exp_hits;
    logic [31:0]        exp_misses;

    int                 value_errors;
    int                 protocol_errors;
    int                 bus_errors;
    int                 cycles;
    string              cur_test;
    logic [`ADDR_W-1:0] exp_burst_addr;
    int                 bursts_seen;
    logic [1:0]         beat_no;
    logic               prev_active;
    logic               prev_ready;
    htrans_t            prev_trans;
    logic [`ADDR_W-1:0] prev_addr;

    ahb_read_cache #(
        .NUM_LINES (NUM_LINES)
    ) u_dut (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hwrite        (hwrite),
        .hsize         (hsize),
        .hready        (hready),
        .hrdata        (hrdata),
        .haddr_m       (haddr_m),
        .htrans_m      (htrans_m),
        .hburst_m      (hburst_m),
        .hready_m      (hready_m),
        .hrdata_m      (hrdata_m),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata)
    );

    mem_model u_mem (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr_m       (haddr_m),
        .htrans_m      (htrans_m),
        .hready_m      (hready_m),
        .hrdata_m      (hrdata_m)
    );

    initial upstream_intf = 1'b0;
    always #50 upstream_intf = ~upstream_intf;

    always @(posedge upstream_intf) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    assert property (@(posedge upstream_intf) disable iff (!rst_n)
        (htrans_m != IDLE) |-> (hburst_m == WRAP4))
    else begin
        bus_errors++;
        $display("downstream transfer in %s is not a WRAP4 burst", cur_test);
    end

    assert property (@(posedge upstream_intf) disable iff (!rst_n)
        (htrans_m != IDLE) |-> (haddr_m[1:0] == 2'b00))
    else begin
        bus_errors++;
        $display("downstream address in %s is not word aligned", cur_test);
    end

    // every accepted downstream beat against the expected wrap sequence
    always @(posedge upstream_intf) begin : downstream_monitor
        logic [`ADDR_W-1:0] beat_addr;
        if (!rst_n) begin
            beat_no     = 2'd0;
            bursts_seen = 0;
            prev_active = 1'b0;
            prev_ready  = 1'b1;
            prev_trans  = IDLE;
            prev_addr   = '0;
        end else begin
            if (prev_active && !prev_ready) begin
                assert (htrans_m == prev_trans && haddr_m == prev_addr) else begin
                    bus_errors++;
                    $display("downstream address phase in %s changed during a wait state",
                             cur_test);
                end
            end
            if (htrans_m != IDLE && hready_m) begin
                beat_addr = {exp_burst_addr[31:4], exp_burst_addr[3:2] + beat_no, 2'b00};
                if (beat_no == 2'd0) begin
                    assert (htrans_m == NONSEQ) else begin
                        bus_errors++;
                        $display("burst in %s does not open with NONSEQ", cur_test);
                    end
                end else begin
                    assert (htrans_m == SEQ) else begin
                        bus_errors++;
                        $display("beat %0d of the burst in %s is not SEQ", beat_no, cur_test);
                    end
                end
                assert (haddr_m == beat_addr) else begin
                    bus_errors++;
                    $display("Fail %s beat address: expected %h, actual %h",
                             cur_test, beat_addr, haddr_m);
                end
                if (beat_no == 2'd3) begin
                    bursts_seen++;
                end
                beat_no = beat_no + 2'd1;
            end
            prev_active = (htrans_m != IDLE);
            prev_ready  = hready_m;
            prev_trans  = htrans_m;
            prev_addr   = haddr_m;
        end
    end

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        value_errors++;
        $display("Fail %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic check_reg(input string name, input logic [1:0] addr,
                             input logic [31:0] exp);
        cfg_addr = addr;
        @(negedge upstream_intf);
        assert (cfg_rdata == exp) else value_mismatch(name, exp, cfg_rdata);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        int i;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge upstream_intf);
        cfg_wr = 1'b0;
        if (addr == `REG_CTRL) begin
            ref_enable = data[0];
            if (data[1]) begin
                for (i = 0; i < NUM_LINES; i++) begin
                    ref_valid[i] = 1'b0;
                end
            end
        end else if (addr == `REG_HITS) begin
            exp_hits = '0;
        end else if (addr == `REG_MISSES) begin
            exp_misses = '0;
        end
    endtask

    // single read, then the data, the timing, the burst count and both counters
    task automatic read_word(input string name, input logic [`ADDR_W-1:0] addr);
        int          idx;
        logic [31:0] tag;
        logic        exp_hit;
        int          lat;
        int          bursts_before;
        idx            = int'(addr[4 +: IDX_W]);
        tag            = addr >> (4 + IDX_W);
        exp_hit        = ref_enable && ref_valid[idx] && (ref_tag[idx] == tag);
        cur_test       = name;
        exp_burst_addr = {addr[31:2], 2'b00};
        bursts_before  = bursts_seen;
        assert (hready) else begin
            protocol_errors++;
            $display("upstream hready is low at the address phase of %s", name);
        end
        haddr  = addr;
        htrans = NONSEQ;
        hwrite = 1'b0;
        @(negedge upstream_intf);
        htrans = IDLE;
        lat    = 1;
        while (!hready) begin
            @(negedge upstream_intf);
            lat++;
        end
        assert (hrdata == ~exp_burst_addr) else
            value_mismatch({name, " data"}, ~exp_burst_addr, hrdata);
        if (exp_hit) begin
            assert (lat == 1) else value_mismatch({name, " hit latency"}, 1, lat);
            exp_hits = exp_hits + 32'd1;
        end else begin
            exp_misses = exp_misses + 32'd1;
            if (ref_enable) begin
                ref_valid[idx] = 1'b1;
                ref_tag[idx]   = tag;
            end
        end
        assert (bursts_seen - bursts_before == (exp_hit ? 0 : 1)) else
            value_mismatch({name, " bursts"}, exp_hit ? 0 : 1, bursts_seen - bursts_before);
        assert (beat_no == 2'd0) else
            value_mismatch({name, " beats left over"}, 0, 32'(beat_no));
        check_reg({name, " hits"}, `REG_HITS, exp_hits);
        check_reg({name, " misses"}, `REG_MISSES, exp_misses);
    endtask

    // writes complete at once and leave the downstream port alone
    task automatic write_transfer(input logic [`ADDR_W-1:0] addr);
        haddr  = addr;
        htrans = NONSEQ;
        hwrite = 1'b1;
        @(negedge upstream_intf);
        htrans = IDLE;
        hwrite = 1'b0;
        assert (hready) else begin
            protocol_errors++;
            $display("upstream write data phase was stalled");
        end
        @(negedge upstream_intf);
        assert (htrans_m == IDLE) else begin
            protocol_errors++;
            $display("upstream write started a downstream burst");
        end
    endtask

    initial begin
        int n;
        void'($urandom(46204));
        rst_n      = 1'b0;
        haddr      = '0;
        htrans     = IDLE;
        hwrite     = 1'b0;
        hsize      = 3'b010;
        cfg_wr     = 1'b0;
        cfg_addr   = 2'd0;
        cfg_wdata  = '0;
        ref_enable = 1'b1;
        exp_hits   = '0;
        exp_misses = '0;
        cur_test   = "reset";
        exp_burst_addr = '0;
        for (n = 0; n < NUM_LINES; n++) begin
            ref_valid[n] = 1'b0;
            ref_tag[n]   = '0;
        end
        repeat (4) @(negedge upstream_intf);
        rst_n = 1'b1;
        @(negedge upstream_intf);

        assert (hready) else value_mismatch("reset hready", 1, 32'(hready));
        assert (htrans_m == IDLE) else value_mismatch("reset htrans_m", 0, 32'(htrans_m));
        check_reg("reset hits", `REG_HITS, 0);
        check_reg("reset misses", `REG_MISSES, 0);
        check_reg("reset ctrl", `REG_CTRL, 1);

        read_word("first miss", 32'h0000_0100);
        read_word("repeat hit", 32'h0000_0100);
        read_word("same line hit", 32'h0000_010C);
        read_word("wrapping miss", 32'h0000_0208);
        read_word("wrapping hit", 32'h0000_0200);

        // same index, different tag
        read_word("conflict a", 32'h0000_0300);
        read_word("conflict b", 32'h0000_0700);
        read_word("conflict a again", 32'h0000_0304);
        read_word("conflict b again", 32'h0000_0708);

        write_transfer(32'h0000_0100);
        read_word("hit after write", 32'h0000_0100);

        write_reg(`REG_CTRL, 32'h3);
        read_word("miss after flush", 32'h0000_0100);
        read_word("hit after refill", 32'h0000_0100);

        write_reg(`REG_CTRL, 32'h0);
        check_reg("ctrl disabled", `REG_CTRL, 0);
        repeat (3) read_word("disabled", 32'h0000_0504);
        read_word("disabled cached line", 32'h0000_0100);
        write_reg(`REG_CTRL, 32'h1);
        read_word("enabled again", 32'h0000_0100);

        write_reg(`REG_HITS, 32'h0);
        check_reg("hits cleared", `REG_HITS, 0);
        write_reg(`REG_MISSES, 32'hFFFF);
        check_reg("misses cleared", `REG_MISSES, 0);

        for (n = 0; n < 50; n++) begin
            read_word("random", ($urandom % 512) << 2);
        end

        $display("value errors: %0d, protocol errors: %0d, bus errors: %0d",
                 value_errors, protocol_errors, bus_errors);
        if (value_errors + protocol_errors + bus_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/ahb_cache_pkg.sv
rtl/ahb_addr_phase.sv
rtl/cache_lookup.sv
rtl/line_refill.sv
rtl/cache_ctrl_regs.sv
rtl/ahb_read_cache.sv
bench/mem_model.sv
bench/tb_ahb_read_cache.sv

//--- rtl/ahb_addr_phase.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module ahb_addr_phase (
    input  logic                       upstream_intf,
    input  logic                       rst_n,
    input  logic [`ADDR_W-1:0]         haddr,
    input  ahb_cache_pkg::htrans_t     htrans,
    input  logic                       hwrite,
    input  logic                       hready,
    output ahb_cache_pkg::lookup_req_t req
);

    import ahb_cache_pkg::*;

    logic active_xfer;
    logic accept_rd;

    assign active_xfer = (htrans == NONSEQ) || (htrans == SEQ);

    // writes are accepted too, but leave nothing for the data phase
    assign accept_rd = hready && active_xfer && !hwrite;

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else if (hready) begin
            req.valid <= accept_rd;
        end
    end

    // address held while the data phase is stalled
    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            req.addr <= '0;
        end else if (accept_rd) begin
            req.addr <= haddr;
        end
    end

endmodule

//--- rtl/ahb_cache_consts.svh
`ifndef AHB_CACHE_CONSTS_SVH
`define AHB_CACHE_CONSTS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32

// words per cache line, 16 bytes
`define LINE_WORDS 4

// register map on the 2-bit config address
`define REG_CTRL   2'd0
`define REG_HITS   2'd1
`define REG_MISSES 2'd2

`endif

//--- rtl/ahb_cache_pkg.sv
`include "ahb_cache_consts.svh"

package ahb_cache_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // only WRAP4 goes out on the memory side
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010
    } hburst_t;

    // one captured upstream read, held through its data phase
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] addr;
    } lookup_req_t;

    typedef struct packed {
        logic               start;
        logic [`ADDR_W-1:0] addr;
    } refill_req_t;

    // word 0 sits in the low bits
    typedef struct packed {
        logic                           done;
        logic [`DATA_W*`LINE_WORDS-1:0] line;
    } refill_rsp_t;

    typedef struct packed {
        logic enable;
        logic flush;
    } cache_cfg_t;

    typedef struct packed {
        logic hit;
        logic miss;
    } cache_event_t;

endpackage

//--- rtl/ahb_read_cache.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module ahb_read_cache #(
    parameter int NUM_LINES = 64
) (
    input  logic                   upstream_intf,
    input  logic                   rst_n,
    // cpu side
    input  logic [`ADDR_W-1:0]     haddr,
    input  ahb_cache_pkg::htrans_t htrans,
    input  logic                   hwrite,
    input  logic [2:0]             hsize,
    output logic                   hready,
    output logic [`DATA_W-1:0]     hrdata,
    // memory side
    output logic [`ADDR_W-1:0]     haddr_m,
    output ahb_cache_pkg::htrans_t htrans_m,
    output ahb_cache_pkg::hburst_t hburst_m,
    input  logic                   hready_m,
    input  logic [`DATA_W-1:0]     hrdata_m,
    // config registers
    input  logic                   cfg_wr,
    input  logic [1:0]             cfg_addr,
    input  logic [`DATA_W-1:0]     cfg_wdata,
    output logic [`DATA_W-1:0]     cfg_rdata
);

    import ahb_cache_pkg::*;

    lookup_req_t  lookup_req;
    refill_req_t  refill_req;
    refill_rsp_t  refill_rsp;
    cache_cfg_t   cfg;
    cache_event_t cache_events;

    ahb_addr_phase u_addr_phase (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hwrite        (hwrite),
        .hready        (hready),
        .req           (lookup_req)
    );

    cache_lookup #(
        .NUM_LINES (NUM_LINES)
    ) u_lookup (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .req           (lookup_req),
        .cfg           (cfg),
        .refill_rsp    (refill_rsp),
        .refill_req    (refill_req),
        .hready        (hready),
        .hrdata        (hrdata),
        .event_out     (cache_events)
    );

    line_refill u_refill (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .req           (refill_req),
        .haddr_m       (haddr_m),
        .htrans_m      (htrans_m),
        .hburst_m      (hburst_m),
        .hready_m      (hready_m),
        .hrdata_m      (hrdata_m),
        .rsp           (refill_rsp)
    );

    cache_ctrl_regs u_regs (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .events        (cache_events),
        .cfg           (cfg)
    );

endmodule

//--- rtl/cache_ctrl_regs.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module cache_ctrl_regs (
    input  logic                        upstream_intf,
    input  logic                        rst_n,
    input  logic                        cfg_wr,
    input  logic [1:0]                  cfg_addr,
    input  logic [`DATA_W-1:0]          cfg_wdata,
    output logic [`DATA_W-1:0]          cfg_rdata,
    input  ahb_cache_pkg::cache_event_t events,
    output ahb_cache_pkg::cache_cfg_t   cfg
);

    logic               enable_q;
    logic               flush_q;
    logic [`DATA_W-1:0] hit_cnt;
    logic [`DATA_W-1:0] miss_cnt;
    logic               wr_ctrl;
    logic               wr_hits;
    logic               wr_misses;

    assign wr_ctrl   = cfg_wr && (cfg_addr == `REG_CTRL);
    assign wr_hits   = cfg_wr && (cfg_addr == `REG_HITS);
    assign wr_misses = cfg_wr && (cfg_addr == `REG_MISSES);

    // bit 0 enable, bit 1 flush
    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end else begin
            flush_q <= wr_ctrl && cfg_wdata[1];
            if (wr_ctrl) begin
                enable_q <= cfg_wdata[0];
            end
        end
    end

    // counters wrap, a write clears
    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else begin
            if (wr_hits) begin
                hit_cnt <= '0;
            end else if (events.hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            if (wr_misses) begin
                miss_cnt <= '0;
            end else if (events.miss) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            `REG_CTRL:   cfg_rdata = {{(`DATA_W-1){1'b0}}, enable_q};
            `REG_HITS:   cfg_rdata = hit_cnt;
            `REG_MISSES: cfg_rdata = miss_cnt;
            default:     cfg_rdata = '0;
        endcase
    end

    assign cfg.enable = enable_q;
    assign cfg.flush  = flush_q;

endmodule

//--- rtl/cache_lookup.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module cache_lookup #(
    parameter int NUM_LINES = 64
) (
    input  logic                        upstream_intf,
    input  logic                        rst_n,
    input  ahb_cache_pkg::lookup_req_t  req,
    input  ahb_cache_pkg::cache_cfg_t   cfg,
    input  ahb_cache_pkg::refill_rsp_t  refill_rsp,
    output ahb_cache_pkg::refill_req_t  refill_req,
    output logic                        hready,
    output logic [`DATA_W-1:0]          hrdata,
    output ahb_cache_pkg::cache_event_t event_out
);

    localparam int OFF_W  = $clog2(`LINE_WORDS);
    localparam int IDX_W  = $clog2(NUM_LINES);
    localparam int TAG_W  = `ADDR_W - IDX_W - OFF_W - 2;
    localparam int LINE_W = `DATA_W * `LINE_WORDS;

    logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
    logic [LINE_W-1:0]    line_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // refill outstanding for the request being held
    logic                 pending;

    logic [OFF_W-1:0]     req_off;
    logic [IDX_W-1:0]     req_idx;
    logic [TAG_W-1:0]     req_tag;
    logic                 tag_hit;
    logic                 lookup_hit;
    logic                 lookup_miss;
    logic                 fill;
    logic [LINE_W-1:0]    sel_line;

    assign req_off = req.addr[2 +: OFF_W];
    assign req_idx = req.addr[2 + OFF_W +: IDX_W];
    assign req_tag = req.addr[`ADDR_W-1 -: TAG_W];

    // disabled cache never hits
    assign tag_hit     = cfg.enable && valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign lookup_hit  = req.valid && !pending && tag_hit;
    assign lookup_miss = req.valid && !pending && !tag_hit;
    assign fill        = refill_rsp.done && cfg.enable;

    assign refill_req.start = lookup_miss;
    assign refill_req.addr  = {req.addr[`ADDR_W-1:2], 2'b00};

    assign hready   = !req.valid || lookup_hit || refill_rsp.done;
    assign sel_line = refill_rsp.done ? refill_rsp.line : line_mem[req_idx];
    assign hrdata   = sel_line[req_off*`DATA_W +: `DATA_W];

    assign event_out.hit  = lookup_hit;
    assign event_out.miss = refill_rsp.done;

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (lookup_miss) begin
            pending <= 1'b1;
        end else if (refill_rsp.done) begin
            pending <= 1'b0;
        end
    end

    // flush drops everything, including a fill in the same cycle
    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (cfg.flush) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (fill) begin
            tag_mem[req_idx]  <= req_tag;
            line_mem[req_idx] <= refill_rsp.line;
        end
    end

endmodule

//--- rtl/line_refill.sv
`timescale 1ns/1ps
`include "ahb_cache_consts.svh"

module line_refill (
    input  logic                       upstream_intf,
    input  logic                       rst_n,
    input  ahb_cache_pkg::refill_req_t req,
    output logic [`ADDR_W-1:0]         haddr_m,
    output ahb_cache_pkg::htrans_t     htrans_m,
    output ahb_cache_pkg::hburst_t     hburst_m,
    input  logic                       hready_m,
    input  logic [`DATA_W-1:0]         hrdata_m,
    output ahb_cache_pkg::refill_rsp_t rsp
);

    import ahb_cache_pkg::*;

    localparam int OFF_W  = $clog2(`LINE_WORDS);
    localparam int LINE_W = `DATA_W * `LINE_WORDS;

    logic [OFF_W-1:0]  beat;
    logic              last_beat;
    logic              addr_accept;
    logic              data_take;

    // data phase state, one beat behind the address
    logic              dph_valid;
    logic              dph_last;
    logic [OFF_W-1:0]  dph_off;

    logic [LINE_W-1:0] line_buf;
    logic              done_q;

    assign last_beat   = (beat == OFF_W'(`LINE_WORDS - 1));
    assign addr_accept = hready_m && (htrans_m != IDLE);
    assign data_take   = hready_m && dph_valid;

    assign hburst_m = (htrans_m == IDLE) ? SINGLE : WRAP4;

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            htrans_m <= IDLE;
            haddr_m  <= '0;
            beat     <= '0;
        end else if (req.start) begin
            htrans_m <= NONSEQ;
            haddr_m  <= req.addr;
            beat     <= '0;
        end else if (addr_accept) begin
            if (last_beat) begin
                htrans_m <= IDLE;
            end else begin
                htrans_m <= SEQ;
                // only the word offset moves, so the address wraps in the line
                haddr_m[2 +: OFF_W] <= haddr_m[2 +: OFF_W] + 1'b1;
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            dph_valid <= 1'b0;
            dph_last  <= 1'b0;
            dph_off   <= '0;
            done_q    <= 1'b0;
        end else begin
            if (hready_m) begin
                dph_valid <= addr_accept;
                dph_last  <= last_beat;
                dph_off   <= haddr_m[2 +: OFF_W];
            end
            done_q <= data_take && dph_last;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (data_take) begin
            line_buf[dph_off*`DATA_W +: `DATA_W] <= hrdata_m;
        end
    end

    assign rsp.done = done_q;
    assign rsp.line = line_buf;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ahb_read_cache -f project.f

out=$(./obj_dir/Vtb_ahb_read_cache)
echo "$out"

# pass only when the testbench reported a clean run
echo "$out" | grep -q "^Done: no errors$"
